// File: design/mipsIsaPkg.sv
// instruction set encodings for the kept integer subset only
// no coprocessor, hi/lo or sub-word opcodes are named here
package mipsIsaPkg;

	// --------------------
	// field types
	typedef logic [31:0] word;        // data or address
	typedef logic [31:0] instrWord;
	typedef logic [4:0]  regIndex;
	typedef logic [15:0] imm16;
	typedef logic [4:0]  shamt;
	typedef logic [5:0]  opcodeField;
	typedef logic [5:0]  functField;

	localparam int REG_COUNT = 32;

	// --------------------
	// opcodes
	localparam opcodeField OP_SPECIAL = 6'b000000;
	localparam opcodeField OP_REGIMM  = 6'b000001;
	localparam opcodeField OP_J       = 6'b000010;
	localparam opcodeField OP_JAL     = 6'b000011;
	localparam opcodeField OP_BEQ     = 6'b000100;
	localparam opcodeField OP_BNE     = 6'b000101;
	localparam opcodeField OP_BLEZ    = 6'b000110;
	localparam opcodeField OP_BGTZ    = 6'b000111;
	localparam opcodeField OP_ADDI    = 6'b001000;
	localparam opcodeField OP_ADDIU   = 6'b001001;
	localparam opcodeField OP_SLTI    = 6'b001010;
	localparam opcodeField OP_SLTIU   = 6'b001011;
	localparam opcodeField OP_ANDI    = 6'b001100; // bit 2 set means zero extended
	localparam opcodeField OP_ORI     = 6'b001101;
	localparam opcodeField OP_XORI    = 6'b001110;
	localparam opcodeField OP_LUI     = 6'b001111;
	localparam opcodeField OP_LW      = 6'b100011;
	localparam opcodeField OP_SW      = 6'b101011;

	// --------------------
	// SPECIAL funct codes
	localparam functField FN_SLL  = 6'b000000;
	localparam functField FN_SRL  = 6'b000010;
	localparam functField FN_SRA  = 6'b000011;
	localparam functField FN_SLLV = 6'b000100;
	localparam functField FN_SRLV = 6'b000110;
	localparam functField FN_SRAV = 6'b000111;
	localparam functField FN_JR   = 6'b001000;
	localparam functField FN_JALR = 6'b001001;
	localparam functField FN_ADD  = 6'b100000;
	localparam functField FN_ADDU = 6'b100001;
	localparam functField FN_SUB  = 6'b100010;
	localparam functField FN_SUBU = 6'b100011;
	localparam functField FN_AND  = 6'b100100;
	localparam functField FN_OR   = 6'b100101;
	localparam functField FN_XOR  = 6'b100110;
	localparam functField FN_NOR  = 6'b100111;
	localparam functField FN_SLT  = 6'b101010;
	localparam functField FN_SLTU = 6'b101011;

	// REGIMM rt codes
	localparam regIndex RT_BLTZ   = 5'b00000;
	localparam regIndex RT_BGEZ   = 5'b00001;
	localparam regIndex RT_BLTZAL = 5'b10000;
	localparam regIndex RT_BGEZAL = 5'b10001;

endpackage

// File: design/idCtrlPkg.sv
// decode stage control encodings shared with the execute stage
// aluOp values are the contract with the ALU, keep them in sync
package idCtrlPkg;

	// --------------------
	// ALU operations, 5 bit encoding
	typedef enum logic [4:0] {
		NOP,
		ADD,
		ADDU,
		SUB,
		SUBU,
		AND,
		OR,
		XOR,
		NOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		SLLV,
		SRLV,
		SRAV,
		LUI
	} aluOp;

	// four-phase input handshake
	typedef enum logic {
		IDLE,
		ACKED
	} hsState;

	localparam mipsIsaPkg::regIndex LINK_REG    = 5'd31; // return address register
	localparam mipsIsaPkg::word     LINK_OFFSET = 32'd4; // added to pcPlus4 for the link value

endpackage

// File: design/instrControl.sv
// main decoder, purely combinational
// encodings outside the kept subset decode to a bubble: NOP, no control bits set
`timescale 1ns/1ps

module instrControl (
	input  mipsIsaPkg::instrWord instr,
	output mipsIsaPkg::regIndex  rs,
	output mipsIsaPkg::regIndex  rt,
	output mipsIsaPkg::regIndex  writeReg,
	output idCtrlPkg::aluOp      aluOperation,
	output logic                 aluSrc,
	output logic                 regWrite,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 memToReg,
	output logic                 link,
	output logic                 jump,
	output logic                 jumpReg,
	output logic                 branch,
	output logic                 signExtend
);

	mipsIsaPkg::opcodeField opcode;
	mipsIsaPkg::functField  funct;
	mipsIsaPkg::regIndex    rd;
	logic                   writeEn; // before the $0 filter

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		aluOperation = idCtrlPkg::NOP;
		aluSrc       = 1'b0;
		writeEn      = 1'b0;
		memRead      = 1'b0;
		memWrite     = 1'b0;
		memToReg     = 1'b0;
		link         = 1'b0;
		jump         = 1'b0;
		jumpReg      = 1'b0;
		branch       = 1'b0;
		signExtend   = 1'b0;
		case (opcode)
			mipsIsaPkg::OP_SPECIAL: begin
				case (funct)
					mipsIsaPkg::FN_SLL:  aluOperation = idCtrlPkg::SLL;
					mipsIsaPkg::FN_SRL:  aluOperation = idCtrlPkg::SRL;
					mipsIsaPkg::FN_SRA:  aluOperation = idCtrlPkg::SRA;
					mipsIsaPkg::FN_SLLV: aluOperation = idCtrlPkg::SLLV;
					mipsIsaPkg::FN_SRLV: aluOperation = idCtrlPkg::SRLV;
					mipsIsaPkg::FN_SRAV: aluOperation = idCtrlPkg::SRAV;
					mipsIsaPkg::FN_ADD:  aluOperation = idCtrlPkg::ADD;
					mipsIsaPkg::FN_ADDU: aluOperation = idCtrlPkg::ADDU;
					mipsIsaPkg::FN_SUB:  aluOperation = idCtrlPkg::SUB;
					mipsIsaPkg::FN_SUBU: aluOperation = idCtrlPkg::SUBU;
					mipsIsaPkg::FN_AND:  aluOperation = idCtrlPkg::AND;
					mipsIsaPkg::FN_OR:   aluOperation = idCtrlPkg::OR;
					mipsIsaPkg::FN_XOR:  aluOperation = idCtrlPkg::XOR;
					mipsIsaPkg::FN_NOR:  aluOperation = idCtrlPkg::NOR;
					mipsIsaPkg::FN_SLT:  aluOperation = idCtrlPkg::SLT;
					mipsIsaPkg::FN_SLTU: aluOperation = idCtrlPkg::SLTU;
					mipsIsaPkg::FN_JR: begin
						jump    = 1'b1;
						jumpReg = 1'b1;
					end
					mipsIsaPkg::FN_JALR: begin
						jump         = 1'b1;
						jumpReg      = 1'b1;
						link         = 1'b1;
						aluOperation = idCtrlPkg::ADD; // pcPlus4 + 4
					end
					default: aluOperation = idCtrlPkg::NOP;
				endcase
				// every SPECIAL op that reaches the ALU writes rd, jr and mult do not
				writeEn = (aluOperation != idCtrlPkg::NOP);
			end
			mipsIsaPkg::OP_REGIMM: begin
				case (rt)
					mipsIsaPkg::RT_BLTZ, mipsIsaPkg::RT_BGEZ: branch = 1'b1;
					mipsIsaPkg::RT_BLTZAL, mipsIsaPkg::RT_BGEZAL: begin
						branch       = 1'b1;
						link         = 1'b1;
						writeEn      = 1'b1; // links even when not taken
						aluOperation = idCtrlPkg::ADD;
					end
					default: branch = 1'b0;
				endcase
			end
			mipsIsaPkg::OP_J: jump = 1'b1;
			mipsIsaPkg::OP_JAL: begin
				jump         = 1'b1;
				link         = 1'b1;
				writeEn      = 1'b1;
				aluOperation = idCtrlPkg::ADD;
			end
			mipsIsaPkg::OP_BEQ, mipsIsaPkg::OP_BNE,
			mipsIsaPkg::OP_BLEZ, mipsIsaPkg::OP_BGTZ: branch = 1'b1;
			mipsIsaPkg::OP_ADDI, mipsIsaPkg::OP_ADDIU,
			mipsIsaPkg::OP_SLTI, mipsIsaPkg::OP_SLTIU,
			mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI,
			mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_LUI: begin
				aluSrc     = 1'b1;
				writeEn    = 1'b1;
				signExtend = !opcode[2]; // logical ops and lui zero extend
				case (opcode)
					mipsIsaPkg::OP_ADDI:  aluOperation = idCtrlPkg::ADD;
					mipsIsaPkg::OP_ADDIU: aluOperation = idCtrlPkg::ADDU;
					mipsIsaPkg::OP_SLTI:  aluOperation = idCtrlPkg::SLT;
					mipsIsaPkg::OP_SLTIU: aluOperation = idCtrlPkg::SLTU;
					mipsIsaPkg::OP_ANDI:  aluOperation = idCtrlPkg::AND;
					mipsIsaPkg::OP_ORI:   aluOperation = idCtrlPkg::OR;
					mipsIsaPkg::OP_XORI:  aluOperation = idCtrlPkg::XOR;
					default:              aluOperation = idCtrlPkg::LUI;
				endcase
			end
			mipsIsaPkg::OP_LW: begin
				aluOperation = idCtrlPkg::ADDU; // address add, no overflow trap
				aluSrc       = 1'b1;
				signExtend   = 1'b1;
				memRead      = 1'b1;
				memToReg     = 1'b1;
				writeEn      = 1'b1;
			end
			mipsIsaPkg::OP_SW: begin
				aluOperation = idCtrlPkg::ADDU;
				aluSrc       = 1'b1;
				signExtend   = 1'b1;
				memWrite     = 1'b1;
			end
			default: aluOperation = idCtrlPkg::NOP;
		endcase
	end

	// --------------------
	// destination select
	assign writeReg = (link && opcode != mipsIsaPkg::OP_SPECIAL) ? idCtrlPkg::LINK_REG :
	                  (opcode == mipsIsaPkg::OP_SPECIAL) ? rd : rt;
	assign regWrite = writeEn && (writeReg != '0); // $0 is never a target

endmodule

// File: design/regFile.sv
// 32 x 32 register file, one write port and two read ports
// same-cycle writeback is forwarded to the reads, $0 reads zero
`timescale 1ns/1ps

module regFile (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                wbEnable,
	input  mipsIsaPkg::regIndex wbReg,
	input  mipsIsaPkg::word     wbData,
	input  mipsIsaPkg::regIndex readRegA,
	input  mipsIsaPkg::regIndex readRegB,
	output mipsIsaPkg::word     readDataA,
	output mipsIsaPkg::word     readDataB
);

	mipsIsaPkg::word regs [mipsIsaPkg::REG_COUNT];

	// one read port with writeback bypass
	function automatic mipsIsaPkg::word readPort(input mipsIsaPkg::regIndex idx);
		if (idx == '0)
			return '0;
		else if (wbEnable && wbReg == idx)
			return wbData;
		else
			return regs[idx];
	endfunction

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			for (int i = 0; i < mipsIsaPkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbEnable && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	always_comb begin
		readDataA = readPort(readRegA);
		readDataB = readPort(readRegB);
	end

endmodule

// File: design/branchResolve.sv
// branch compare and next address, combinational
// compares are signed, branch offset is relative to pcPlus4 (no delay slot handling)
`timescale 1ns/1ps

module branchResolve (
	input  mipsIsaPkg::instrWord instr,
	input  mipsIsaPkg::word      pcPlus4,
	input  mipsIsaPkg::word      opA,
	input  mipsIsaPkg::word      opB,
	input  logic                 jump,
	input  logic                 jumpReg,
	input  logic                 branch,
	output logic                 taken,
	output mipsIsaPkg::word      targetPc
);

	mipsIsaPkg::opcodeField opcode;
	mipsIsaPkg::regIndex    rtCode;
	mipsIsaPkg::word        offset;
	logic                   negative;
	logic                   zero;
	logic                   condMet;

	assign opcode   = instr[31:26];
	assign rtCode   = instr[20:16];
	assign offset   = {{14{instr[15]}}, instr[15:0], 2'b00}; // word offset
	assign negative = opA[31];
	assign zero     = (opA == '0);

	// --------------------
	// condition per opcode
	always_comb begin
		case (opcode)
			mipsIsaPkg::OP_BEQ:  condMet = (opA == opB);
			mipsIsaPkg::OP_BNE:  condMet = (opA != opB);
			mipsIsaPkg::OP_BLEZ: condMet = negative || zero;
			mipsIsaPkg::OP_BGTZ: condMet = !negative && !zero;
			mipsIsaPkg::OP_REGIMM: begin
				case (rtCode)
					mipsIsaPkg::RT_BLTZ, mipsIsaPkg::RT_BLTZAL: condMet = negative;
					mipsIsaPkg::RT_BGEZ, mipsIsaPkg::RT_BGEZAL: condMet = !negative;
					default: condMet = 1'b0;
				endcase
			end
			default: condMet = 1'b0;
		endcase
	end

	assign taken = jump || (branch && condMet);

	always_comb begin
		if (jumpReg)
			targetPc = opA;
		else if (jump)
			targetPc = {pcPlus4[31:28], instr[25:0], 2'b00}; // 256 MB region
		else if (branch && condMet)
			targetPc = pcPlus4 + offset;
		else
			targetPc = pcPlus4;
	end

endmodule

// File: design/idExRegister.sv
// ID/EX register with four-phase req/ack toward fetch
// outputs hold until the next capture, outValid marks the cycle after capture
`timescale 1ns/1ps

module idExRegister (
	input  logic                 CLK,
	input  logic                 RESET,
	input  logic                 instrReq,
	input  mipsIsaPkg::instrWord instr,
	input  mipsIsaPkg::word      pcPlus4,
	input  mipsIsaPkg::word      readDataA,
	input  mipsIsaPkg::word      readDataB,
	input  idCtrlPkg::aluOp      decAluOp,
	input  logic                 decAluSrc,
	input  logic                 decRegWrite,
	input  logic                 decMemRead,
	input  logic                 decMemWrite,
	input  logic                 decMemToReg,
	input  logic                 decLink,
	input  mipsIsaPkg::regIndex  decWriteReg,
	input  logic                 taken,
	input  mipsIsaPkg::word      targetPc,
	output logic                 instrAck,
	output logic                 outValid,
	output idCtrlPkg::aluOp      aluOperation,
	output mipsIsaPkg::word      operandA,
	output mipsIsaPkg::word      operandB,
	output mipsIsaPkg::imm16     immediate,
	output mipsIsaPkg::shamt     shiftAmount,
	output mipsIsaPkg::regIndex  destReg,
	output logic                 regWriteOut,
	output logic                 memReadOut,
	output logic                 memWriteOut,
	output logic                 memToRegOut,
	output logic                 aluSrcOut,
	output logic                 branchTaken,
	output mipsIsaPkg::word      nextPc
);

	idCtrlPkg::hsState state;
	logic              capture;

	assign capture  = (state == idCtrlPkg::IDLE) && instrReq;
	assign instrAck = (state == idCtrlPkg::ACKED);

	// --------------------
	// handshake FSM
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			state <= idCtrlPkg::IDLE;
		end else begin
			case (state)
				idCtrlPkg::IDLE: begin
					if (instrReq)
						state <= idCtrlPkg::ACKED;
				end
				idCtrlPkg::ACKED: begin
					if (!instrReq) // fetch has seen the ack
						state <= idCtrlPkg::IDLE;
				end
				default: state <= idCtrlPkg::IDLE;
			endcase
		end
	end

	// --------------------
	// control half of the pipeline register
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			outValid     <= 1'b0;
			aluOperation <= idCtrlPkg::NOP;
			regWriteOut  <= 1'b0;
			memReadOut   <= 1'b0;
			memWriteOut  <= 1'b0;
			memToRegOut  <= 1'b0;
			aluSrcOut    <= 1'b0;
			branchTaken  <= 1'b0;
		end else begin
			outValid <= capture; // one cycle per instruction
			if (capture) begin
				aluOperation <= decAluOp;
				regWriteOut  <= decRegWrite;
				memReadOut   <= decMemRead;
				memWriteOut  <= decMemWrite;
				memToRegOut  <= decMemToReg;
				aluSrcOut    <= decAluSrc;
				branchTaken  <= taken;
			end
		end
	end

	// data half, links turn into pcPlus4 + 4 in execute
	always_ff @(posedge CLK) begin
		if (capture) begin
			operandA    <= decLink ? pcPlus4 : readDataA;
			operandB    <= decLink ? idCtrlPkg::LINK_OFFSET : readDataB;
			immediate   <= instr[15:0];
			shiftAmount <= instr[10:6];
			destReg     <= decWriteReg;
			nextPc      <= targetPc;
		end
	end

endmodule

// File: design/decodeStage.sv
// decode stage top, fetch side is four-phase req/ack
// no back-pressure from execute, results are valid for one cycle
`timescale 1ns/1ps

module decodeStage (
	input  logic                 CLK,
	input  logic                 RESET,
	input  logic                 instrReq,
	input  mipsIsaPkg::instrWord instr,
	input  mipsIsaPkg::word      pcPlus4,
	output logic                 instrAck,
	input  logic                 wbEnable,
	input  mipsIsaPkg::regIndex  wbReg,
	input  mipsIsaPkg::word      wbData,
	output logic                 outValid,
	output idCtrlPkg::aluOp      aluOperation,
	output mipsIsaPkg::word      operandA,
	output mipsIsaPkg::word      operandB,
	output mipsIsaPkg::imm16     immediate,
	output mipsIsaPkg::shamt     shiftAmount,
	output mipsIsaPkg::regIndex  destReg,
	output logic                 regWriteOut,
	output logic                 memReadOut,
	output logic                 memWriteOut,
	output logic                 memToRegOut,
	output logic                 aluSrcOut,
	output logic                 branchTaken,
	output mipsIsaPkg::word      nextPc
);

	mipsIsaPkg::regIndex rs;
	mipsIsaPkg::regIndex rt;
	mipsIsaPkg::regIndex writeReg;
	idCtrlPkg::aluOp     decAluOp;
	logic                aluSrc;
	logic                regWrite;
	logic                memRead;
	logic                memWrite;
	logic                memToReg;
	logic                link;
	logic                jump;
	logic                jumpReg;
	logic                branch;
	mipsIsaPkg::word     readDataA;
	mipsIsaPkg::word     readDataB;
	logic                taken;
	mipsIsaPkg::word     targetPc;

	instrControl i_instrControl (
		.instr       (instr),
		.rs          (rs),
		.rt          (rt),
		.writeReg    (writeReg),
		.aluOperation(decAluOp),
		.aluSrc      (aluSrc),
		.regWrite    (regWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.memToReg    (memToReg),
		.link        (link),
		.jump        (jump),
		.jumpReg     (jumpReg),
		.branch      (branch),
		.signExtend  ()          // immediate leaves raw, execute extends
	);

	regFile i_regFile (
		.CLK      (CLK),
		.RESET    (RESET),
		.wbEnable (wbEnable),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.readRegA (rs),
		.readRegB (rt),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	branchResolve i_branchResolve (
		.instr   (instr),
		.pcPlus4 (pcPlus4),
		.opA     (readDataA),
		.opB     (readDataB),
		.jump    (jump),
		.jumpReg (jumpReg),
		.branch  (branch),
		.taken   (taken),
		.targetPc(targetPc)
	);

	idExRegister i_idExRegister (
		.CLK         (CLK),
		.RESET       (RESET),
		.instrReq    (instrReq),
		.instr       (instr),
		.pcPlus4     (pcPlus4),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.decAluOp    (decAluOp),
		.decAluSrc   (aluSrc),
		.decRegWrite (regWrite),
		.decMemRead  (memRead),
		.decMemWrite (memWrite),
		.decMemToReg (memToReg),
		.decLink     (link),
		.decWriteReg (writeReg),
		.taken       (taken),
		.targetPc    (targetPc),
		.instrAck    (instrAck),
		.outValid    (outValid),
		.aluOperation(aluOperation),
		.operandA    (operandA),
		.operandB    (operandB),
		.immediate   (immediate),
		.shiftAmount (shiftAmount),
		.destReg     (destReg),
		.regWriteOut (regWriteOut),
		.memReadOut  (memReadOut),
		.memWriteOut (memWriteOut),
		.memToRegOut (memToRegOut),
		.aluSrcOut   (aluSrcOut),
		.branchTaken (branchTaken),
		.nextPc      (nextPc)
	);

endmodule

// File: test/decodeStage_chk.sv
// handshake and reset properties bound into the decode stage top
`timescale 1ns/1ps

module decodeStage_chk (
	input logic                CLK,
	input logic                RESET,
	input logic                instrReq,
	input logic                instrAck,
	input logic                outValid,
	input idCtrlPkg::aluOp     aluOperation,
	input mipsIsaPkg::regIndex destReg,
	input logic                regWriteOut,
	input logic                memReadOut,
	input logic                memWriteOut,
	input logic                memToRegOut,
	input logic                branchTaken
);

	int assertFails = 0;

	// one result per transaction
	singleValid: assert property (@(posedge CLK) disable iff (!RESET)
		outValid |=> !outValid)
		else begin
			$error("outValid high for two cycles");
			assertFails++;
		end

	ackRelease: assert property (@(posedge CLK) disable iff (!RESET)
		$fell(instrAck) |-> !$past(instrReq))
		else begin
			$error("instrAck fell while instrReq was high");
			assertFails++;
		end

	noZeroWrite: assert property (@(posedge CLK) disable iff (!RESET)
		regWriteOut |-> destReg != '0)
		else begin
			$error("regWriteOut set with destReg 0");
			assertFails++;
		end

	resetQuiet: assert property (@(posedge CLK)
		!RESET |-> (!instrAck && !outValid && !regWriteOut && !memReadOut && !memWriteOut
		            && !memToRegOut && !branchTaken && aluOperation == idCtrlPkg::NOP))
		else begin
			$error("control outputs active during reset");
			assertFails++;
		end

endmodule

bind decodeStage decodeStage_chk i_decodeStageChk (
	.CLK         (CLK),
	.RESET       (RESET),
	.instrReq    (instrReq),
	.instrAck    (instrAck),
	.outValid    (outValid),
	.aluOperation(aluOperation),
	.destReg     (destReg),
	.regWriteOut (regWriteOut),
	.memReadOut  (memReadOut),
	.memWriteOut (memWriteOut),
	.memToRegOut (memToRegOut),
	.branchTaken (branchTaken)
);

// File: test/decodeMonitor.sv
// compares decode results with the trace in the cycle where outValid is high
// a test ends when instrAck falls, one outValid is expected per test
`timescale 1ns/1ps

module decodeMonitor (
	input  logic                 CLK,
	input  logic                 instrAck,
	input  logic                 outValid,
	input  idCtrlPkg::aluOp      aluOperation,
	input  mipsIsaPkg::word      operandA,
	input  mipsIsaPkg::word      operandB,
	input  mipsIsaPkg::imm16     immediate,
	input  mipsIsaPkg::shamt     shiftAmount,
	input  mipsIsaPkg::regIndex  destReg,
	input  logic                 regWriteOut,
	input  logic                 memReadOut,
	input  logic                 memWriteOut,
	input  logic                 memToRegOut,
	input  logic                 aluSrcOut,
	input  logic                 branchTaken,
	input  mipsIsaPkg::word      nextPc,
	input  int                   testNum,
	input  mipsIsaPkg::instrWord expInstr,
	input  logic [4:0]           expAluOp,
	input  mipsIsaPkg::word      expOpA,
	input  mipsIsaPkg::word      expOpB,
	input  mipsIsaPkg::regIndex  expDest,
	input  logic                 expRegWrite,
	input  logic                 expMemRead,
	input  logic                 expMemWrite,
	input  logic                 expMemToReg,
	input  logic                 expAluSrc,
	input  logic                 expTaken,
	input  mipsIsaPkg::word      expNextPc,
	output int                   passCount,
	output int                   failCount
);

	int   testErrors;
	logic resultSeen;
	logic ackPrev;   // instrAck at the previous falling edge

	task automatic compareValue(input string name, input logic [31:0] expected,
	                            input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
			         $time, name, expected, actual);
			testErrors++;
		end
	endtask

	initial begin
		passCount  = 0;
		failCount  = 0;
		testErrors = 0;
		resultSeen = 1'b0;
		ackPrev    = 1'b0;
	end

	// outputs are stable mid cycle
	always @(negedge CLK) begin
		if (outValid) begin
			if (resultSeen) begin
				$display("time %0t: test %0d saw a second outValid", $time, testNum);
				testErrors++;
			end
			compareValue("aluOperation", expAluOp, aluOperation);
			compareValue("operandA", expOpA, operandA);
			compareValue("operandB", expOpB, operandB);
			compareValue("immediate", expInstr[15:0], immediate);   // raw field
			compareValue("shiftAmount", expInstr[10:6], shiftAmount);
			compareValue("destReg", expDest, destReg);
			compareValue("regWriteOut", expRegWrite, regWriteOut);
			compareValue("memReadOut", expMemRead, memReadOut);
			compareValue("memWriteOut", expMemWrite, memWriteOut);
			compareValue("memToRegOut", expMemToReg, memToRegOut);
			compareValue("aluSrcOut", expAluSrc, aluSrcOut);
			compareValue("branchTaken", expTaken, branchTaken);
			compareValue("nextPc", expNextPc, nextPc);
			resultSeen = 1'b1;
		end
		if (ackPrev && !instrAck) begin
			if (!resultSeen) begin
				$display("time %0t: test %0d finished its handshake without outValid",
				         $time, testNum);
				testErrors++;
			end
			if (testErrors == 0) begin
				passCount++;
				$display("test %0d instr %h: ok", testNum, expInstr);
			end else begin
				failCount++;
				$display("test %0d instr %h: FAILED, %0d errors", testNum, expInstr, testErrors);
			end
			testErrors = 0;
			resultSeen = 1'b0;
		end
		ackPrev = instrAck;
	end

endmodule

// File: test/decodeStageTb.sv
// stimulus and expected results come from test/decodeTrace.txt
// run from the project root so the trace path resolves
`timescale 1ns/1ps

module decodeStageTb;

	localparam int CLK_PERIOD   = 4;
	localparam int LINE_CYCLES  = 20;   // watchdog budget per trace line
	localparam     TRACE_PATH   = "test/decodeTrace.txt";

	logic                 CLK;
	logic                 RESET;
	logic                 instrReq;
	mipsIsaPkg::instrWord instr;
	mipsIsaPkg::word      pcPlus4;
	logic                 instrAck;
	logic                 wbEnable;
	mipsIsaPkg::regIndex  wbReg;
	mipsIsaPkg::word      wbData;
	logic                 outValid;
	idCtrlPkg::aluOp      aluOperation;
	mipsIsaPkg::word      operandA;
	mipsIsaPkg::word      operandB;
	mipsIsaPkg::imm16     immediate;
	mipsIsaPkg::shamt     shiftAmount;
	mipsIsaPkg::regIndex  destReg;
	logic                 regWriteOut;
	logic                 memReadOut;
	logic                 memWriteOut;
	logic                 memToRegOut;
	logic                 aluSrcOut;
	logic                 branchTaken;
	mipsIsaPkg::word      nextPc;

	// --------------------
	// expectations of the current I line
	int                   testNum;
	mipsIsaPkg::instrWord expInstr;
	mipsIsaPkg::word      expPc;
	logic [4:0]           expAluOp;
	mipsIsaPkg::word      expOpA;
	mipsIsaPkg::word      expOpB;
	mipsIsaPkg::regIndex  expDest;
	logic                 expRegWrite;
	logic                 expMemRead;
	logic                 expMemWrite;
	logic                 expMemToReg;
	logic                 expAluSrc;
	logic                 expTaken;
	mipsIsaPkg::word      expNextPc;

	logic                 holdPending;  // writeback saved for the next capture edge
	mipsIsaPkg::regIndex  holdReg;
	mipsIsaPkg::word      holdData;
	int                   traceLines;
	logic                 traceCounted;
	int                   tbErrors;
	int                   passCount;
	int                   failCount;

	decodeStage i_decodeStage (
		.CLK         (CLK),
		.RESET       (RESET),
		.instrReq    (instrReq),
		.instr       (instr),
		.pcPlus4     (pcPlus4),
		.instrAck    (instrAck),
		.wbEnable    (wbEnable),
		.wbReg       (wbReg),
		.wbData      (wbData),
		.outValid    (outValid),
		.aluOperation(aluOperation),
		.operandA    (operandA),
		.operandB    (operandB),
		.immediate   (immediate),
		.shiftAmount (shiftAmount),
		.destReg     (destReg),
		.regWriteOut (regWriteOut),
		.memReadOut  (memReadOut),
		.memWriteOut (memWriteOut),
		.memToRegOut (memToRegOut),
		.aluSrcOut   (aluSrcOut),
		.branchTaken (branchTaken),
		.nextPc      (nextPc)
	);

	decodeMonitor i_decodeMonitor (
		.CLK         (CLK),
		.instrAck    (instrAck),
		.outValid    (outValid),
		.aluOperation(aluOperation),
		.operandA    (operandA),
		.operandB    (operandB),
		.immediate   (immediate),
		.shiftAmount (shiftAmount),
		.destReg     (destReg),
		.regWriteOut (regWriteOut),
		.memReadOut  (memReadOut),
		.memWriteOut (memWriteOut),
		.memToRegOut (memToRegOut),
		.aluSrcOut   (aluSrcOut),
		.branchTaken (branchTaken),
		.nextPc      (nextPc),
		.testNum     (testNum),
		.expInstr    (expInstr),
		.expAluOp    (expAluOp),
		.expOpA      (expOpA),
		.expOpB      (expOpB),
		.expDest     (expDest),
		.expRegWrite (expRegWrite),
		.expMemRead  (expMemRead),
		.expMemWrite (expMemWrite),
		.expMemToReg (expMemToReg),
		.expAluSrc   (expAluSrc),
		.expTaken    (expTaken),
		.expNextPc   (expNextPc),
		.passCount   (passCount),
		.failCount   (failCount)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// one-cycle writeback driven on the falling edge
	task automatic writeBack(input mipsIsaPkg::regIndex idx, input mipsIsaPkg::word data);
		@(negedge CLK);
		wbEnable = 1'b1;
		wbReg    = idx;
		wbData   = data;
		@(negedge CLK);
		wbEnable = 1'b0;
	endtask

	// full four-phase transaction for one instruction
	task automatic issueInstr;
		@(negedge CLK);
		testNum++;
		instr    = expInstr;
		pcPlus4  = expPc;
		instrReq = 1'b1;
		if (holdPending) begin
			wbEnable = 1'b1;   // lands on the capture edge
			wbReg    = holdReg;
			wbData   = holdData;
		end
		@(negedge CLK);
		wbEnable    = 1'b0;
		holdPending = 1'b0;
		while (!instrAck)
			@(negedge CLK);
		instrReq = 1'b0;
		while (instrAck)
			@(negedge CLK);
		@(posedge CLK);    // next line is parsed away from the monitor's edge
	endtask

	// --------------------
	// watchdog
	initial begin
		wait (traceCounted);
		#(traceLines * LINE_CYCLES * CLK_PERIOD);
		$display("timeout: trace not finished after %0d cycles", traceLines * LINE_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int               fd;
		int               code;
		logic [7:0]       kind;
		logic [8*160-1:0] rest;
		logic [31:0]      regVal;
		logic [31:0]      dataVal;
		int               hold;
		int               chkFails;
		CLK          = 1'b0;
		RESET        = 1'b0;
		instrReq     = 1'b0;
		instr        = '0;
		pcPlus4      = '0;
		wbEnable     = 1'b0;
		wbReg        = '0;
		wbData       = '0;
		testNum      = 0;
		holdPending  = 1'b0;
		traceLines   = 0;
		traceCounted = 1'b0;
		tbErrors     = 0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", TRACE_PATH);
			$display("Simulation failed");
			$finish;
		end else begin
			// first pass only sizes the watchdog
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", kind);
				if (code == 1) begin
					if (kind == "W" || kind == "I")
						traceLines++;
					code = $fgets(rest, fd);
				end
			end
			$fclose(fd);
			traceCounted = 1'b1;
			fd = $fopen(TRACE_PATH, "r");
			repeat (2) @(negedge CLK);
			RESET = 1'b1;
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1) begin
					kind = " ";   // end of file
				end else if (kind == "W") begin
					code = $fscanf(fd, "%h %h %d", regVal, dataVal, hold);
					if (code != 3) begin
						$display("malformed W line in trace");
						tbErrors++;
					end else if (hold != 0) begin
						holdPending = 1'b1;
						holdReg     = regVal[4:0];
						holdData    = dataVal;
					end else begin
						writeBack(regVal[4:0], dataVal);
					end
				end else if (kind == "I") begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					               expInstr, expPc, expAluOp, expOpA, expOpB, expDest,
					               expRegWrite, expMemRead, expMemWrite, expMemToReg,
					               expAluSrc, expTaken, expNextPc);
					if (code != 13) begin
						$display("malformed I line in trace");
						tbErrors++;
					end else begin
						issueInstr();
					end
				end else begin
					code = $fgets(rest, fd);   // comment line
				end
			end
			$fclose(fd);
			repeat (2) @(negedge CLK);
			chkFails = i_decodeStage.i_decodeStageChk.assertFails;
			$display("tests passed %0d, failed %0d, trace errors %0d, assertion failures %0d",
			         passCount, failCount, tbErrors, chkFails);
			if (failCount == 0 && tbErrors == 0 && chkFails == 0 && testNum > 0
			    && passCount == testNum)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: test/decodeTrace.txt
# W reg data hold (hex, hex, 0 = write now, 1 = write on the next capture edge)
# I instr pcPlus4 aluOp opA opB dest regWr memRd memWr memToReg aluSrc taken nextPc
W 01 0000000a 0
W 02 00000003 0
W 03 fffffff0 0
W 04 0000000a 0
W 05 00000040 0
# R-type add sub slt xor, then add to $0
I 00223020 00001004 01 0000000a 00000003 06 1 0 0 0 0 0 00001004
I 00223822 00001004 03 0000000a 00000003 07 1 0 0 0 0 0 00001004
I 0061402a 00001004 09 fffffff0 0000000a 08 1 0 0 0 0 0 00001004
I 00244826 00001004 07 0000000a 0000000a 09 1 0 0 0 0 0 00001004
I 00220020 00001004 01 0000000a 00000003 00 0 0 0 0 0 0 00001004
# addi ori lw sw
I 202afffc 00001004 01 0000000a 00000000 0a 1 0 0 0 1 0 00001004
I 344b00ff 00001004 06 00000003 00000000 0b 1 0 0 0 1 0 00001004
I 8c2c0008 00001004 02 0000000a 00000000 0c 1 1 0 1 1 0 00001004
I ac220004 00001004 02 0000000a 00000003 02 0 0 1 0 1 0 00001004
# branches beq bne bltz bgez blez bgtz
I 10240010 00002000 00 0000000a 0000000a 04 0 0 0 0 0 1 00002040
I 10220010 00002000 00 0000000a 00000003 02 0 0 0 0 0 0 00002000
I 1422fffe 00002000 00 0000000a 00000003 02 0 0 0 0 0 1 00001ff8
I 04600010 00002000 00 fffffff0 00000000 00 0 0 0 0 0 1 00002040
I 04400010 00002000 00 00000003 00000000 00 0 0 0 0 0 0 00002000
I 04010010 00002000 00 00000000 0000000a 01 0 0 0 0 0 1 00002040
I 04610010 00002000 00 fffffff0 0000000a 01 0 0 0 0 0 0 00002000
I 18000010 00002000 00 00000000 00000000 00 0 0 0 0 0 1 00002040
I 18400010 00002000 00 00000003 00000000 00 0 0 0 0 0 0 00002000
I 1c400010 00002000 00 00000003 00000000 00 0 0 0 0 0 1 00002040
I 1c600010 00002000 00 fffffff0 00000000 00 0 0 0 0 0 0 00002000
# j jal jr jalr bgezal
I 08123456 30000100 00 00000000 00000000 12 0 0 0 0 0 1 3048d158
I 0c123456 30000100 01 30000100 00000004 1f 1 0 0 0 0 1 3048d158
I 00a00008 30000100 00 00000040 00000000 00 0 0 0 0 0 1 00000040
I 00a0f809 30000100 01 30000100 00000004 1f 1 0 0 0 0 1 00000040
I 04510010 00002000 01 00002000 00000004 1f 1 0 0 0 0 1 00002040
# unsupported cop1 and mult
I 46020800 00001004 00 00000000 00000003 02 0 0 0 0 0 0 00001004
I 00220018 00001004 00 0000000a 00000003 00 0 0 0 0 0 0 00001004
# bypass at the capture edge, then $0 stays zero
W 01 12345678 1
I 00226820 00001004 01 12345678 00000003 0d 1 0 0 0 0 0 00001004
W 00 deadbeef 1
I 00017020 00001004 01 00000000 12345678 0e 1 0 0 0 0 0 00001004

// File: sources.f
design/mipsIsaPkg.sv
design/idCtrlPkg.sv
design/instrControl.sv
design/regFile.sv
design/branchResolve.sv
design/idExRegister.sv
design/decodeStage.sv
test/decodeStage_chk.sv
test/decodeMonitor.sv
test/decodeStageTb.sv
